//--- i2c_pkg.sv
package i2c_pkg;

    // number of independent buses
    localparam int CHAN_COUNT = 2;

    // transfer size limits
    localparam int MAX_BYTES = 4;
    localparam int NBYTES_W  = 3;
    localparam int DATA_W    = 8 * MAX_BYTES;

    typedef logic [6:0] i2c_addr_t;

    // one queued bus transaction
    typedef struct packed {
        i2c_addr_t           addr;
        logic                rw;
        logic [NBYTES_W-1:0] nbytes;
        // most significant used byte goes out first
        logic [DATA_W-1:0]   wdata;
        logic                stop;
    } i2c_cmd_t;

    // outcome of one transaction
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic                nack;
        logic [NBYTES_W-1:0] nbytes_done;
    } i2c_rsp_t;

    // result as seen by the host, tagged with its bus
    typedef struct packed {
        logic     chan;
        i2c_rsp_t rsp;
    } i2c_tagged_rsp_t;

endpackage

//--- credit_fifo.sv
`timescale 1ns/10ps

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     not_full,
    output logic     credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push   = push && not_full;
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign not_full  = (count != CW'(DEPTH));
    // one credit back per entry freed
    assign credit    = do_pop;
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- i2c_master.sv
`timescale 1ns/10ps

module i2c_master #(
    parameter int DIVIDER = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_ready,
    input  i2c_pkg::i2c_cmd_t  cmd,
    output logic               cmd_pop,
    output logic               rsp_valid,
    input  logic               rsp_accept,
    output i2c_pkg::i2c_rsp_t  rsp,
    output logic               scl_low,
    output logic               sda_oe,
    input  logic               sda_in
);

    import i2c_pkg::*;

    localparam int TW = (DIVIDER > 1) ? $clog2(DIVIDER) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_RTX,
        ST_ACK,
        ST_STOP,
        ST_DONE
    } state_t;

    state_t              state;
    logic [TW-1:0]       tick_cnt;
    logic                tick;
    logic [1:0]          step;
    logic [2:0]          bit_cnt;
    logic [NBYTES_W-1:0] byte_n;
    logic                data_mode;
    logic                last_byte;
    logic                bit_end;

    // transaction payload
    i2c_cmd_t            cmd_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [DATA_W-1:0]   rdata_q;
    logic [7:0]          sh;
    logic                nack_q;

    // clk / DIVIDER tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick      = (tick_cnt == TW'(DIVIDER - 1));
    assign bit_end   = tick && (step == 2'd2);
    assign last_byte = ((byte_n + 1'b1) == cmd_q.nbytes);
    // hold off while someone else keeps SDA low
    assign cmd_pop   = (state == ST_IDLE) && tick && cmd_ready && sda_in;
    assign rsp_valid = (state == ST_DONE);
    assign rsp       = '{rdata: rdata_q, nack: nack_q, nbytes_done: byte_n};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            step      <= '0;
            bit_cnt   <= '0;
            byte_n    <= '0;
            data_mode <= 1'b0;
            scl_low   <= 1'b0;
            sda_oe    <= 1'b0;
        end else if (state == ST_DONE) begin
            // result held until the queue takes it
            if (rsp_accept) begin
                state <= ST_IDLE;
            end
        end else if (tick) begin
            case (state)
                ST_IDLE: begin
                    if (cmd_pop) begin
                        scl_low <= 1'b0;
                        byte_n  <= '0;
                        step    <= '0;
                        state   <= ST_START;
                    end
                end
                ST_START: begin
                    step <= step + 1'b1;
                    if (step == 2'd0) begin
                        sda_oe <= 1'b0;
                    end else if (step == 2'd1) begin
                        sda_oe <= 1'b1;
                    end else begin
                        scl_low   <= 1'b1;
                        bit_cnt   <= '0;
                        data_mode <= 1'b0;
                        step      <= '0;
                        state     <= ST_RTX;
                    end
                end
                ST_RTX: begin
                    step <= step + 1'b1;
                    if (step == 2'd0) begin
                        // release SDA while receiving data
                        sda_oe <= (!data_mode || !cmd_q.rw) ? !sh[7] : 1'b0;
                    end else if (step == 2'd1) begin
                        scl_low <= 1'b0;
                    end else begin
                        scl_low <= 1'b1;
                        step    <= '0;
                        if (bit_cnt == 3'd7) begin
                            bit_cnt <= '0;
                            state   <= ST_ACK;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_ACK: begin
                    step <= step + 1'b1;
                    if (step == 2'd0) begin
                        // ack every read byte but the last
                        sda_oe <= data_mode && cmd_q.rw && !last_byte;
                    end else if (step == 2'd1) begin
                        scl_low <= 1'b0;
                    end else begin
                        scl_low <= 1'b1;
                        step    <= '0;
                        if (!data_mode) begin
                            if (sda_in) begin
                                state <= ST_STOP;
                            end else begin
                                data_mode <= 1'b1;
                                state     <= ST_RTX;
                            end
                        end else begin
                            byte_n <= byte_n + 1'b1;
                            if (!last_byte) begin
                                state <= ST_RTX;
                            end else if (cmd_q.stop) begin
                                state <= ST_STOP;
                            end else begin
                                // SCL stays low for a repeated start
                                state <= ST_DONE;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    step <= step + 1'b1;
                    if (step == 2'd0) begin
                        sda_oe <= 1'b1;
                    end else if (step == 2'd1) begin
                        scl_low <= 1'b0;
                    end else if (step == 2'd2) begin
                        sda_oe <= 1'b0;
                    end else begin
                        step  <= '0;
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cmd_q   <= cmd;
            // left align so the first byte sits at the top
            wdata_q <= cmd.wdata << (8 * (MAX_BYTES - int'(cmd.nbytes)));
            rdata_q <= '0;
            nack_q  <= 1'b0;
        end else if (bit_end) begin
            if (state == ST_START) begin
                sh <= {cmd_q.addr, cmd_q.rw};
            end else if (state == ST_RTX) begin
                sh <= {sh[6:0], sda_in};
            end else if (state == ST_ACK) begin
                sh      <= wdata_q[DATA_W-1 -: 8];
                wdata_q <= wdata_q << 8;
                if (!data_mode) begin
                    nack_q <= sda_in;
                end else if (cmd_q.rw) begin
                    rdata_q <= {rdata_q[DATA_W-9:0], sh};
                end
            end
        end
    end

endmodule

//--- result_merger.sv
`timescale 1ns/10ps

module result_merger #(
    parameter int OUT_CREDITS = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  i2c_pkg::i2c_rsp_t         rsp0,
    input  i2c_pkg::i2c_rsp_t         rsp1,
    input  logic                      avail0,
    input  logic                      avail1,
    output logic                      pop0,
    output logic                      pop1,
    output logic                      rsp_valid,
    output i2c_pkg::i2c_tagged_rsp_t  rsp,
    input  logic                      rsp_credit
);

    import i2c_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);

    logic [CW-1:0]         credits;
    logic [CHAN_COUNT-1:0] avail;
    logic [CHAN_COUNT-1:0] grant;
    logic                  last_chan;
    logic                  sel;
    logic                  fire;

    assign avail = {avail1, avail0};
    assign fire  = (credits != '0) && (avail != '0);
    // alternate when both wait, else take whichever has one
    assign sel   = (&avail) ? ~last_chan : avail[1];
    assign grant = fire ? (CHAN_COUNT'(1) << sel) : '0;
    assign pop0  = grant[0];
    assign pop1  = grant[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits   <= CW'(OUT_CREDITS);
            last_chan <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fire;
            if (fire) begin
                last_chan <= sel;
            end
            if (rsp_credit && !fire) begin
                credits <= credits + 1'b1;
            end else if (fire && !rsp_credit) begin
                credits <= credits - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rsp <= '{chan: sel, rsp: (sel ? rsp1 : rsp0)};
        end
    end

endmodule

//--- i2c_dual_top.sv
`timescale 1ns/10ps

module i2c_dual_top #(
    parameter int DIVIDER     = 4,
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_DEPTH   = 2,
    parameter int OUT_CREDITS = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid_0,
    input  i2c_pkg::i2c_cmd_t         cmd_0,
    output logic                      cmd_credit_0,
    input  logic                      cmd_valid_1,
    input  i2c_pkg::i2c_cmd_t         cmd_1,
    output logic                      cmd_credit_1,
    output logic                      rsp_valid,
    output i2c_pkg::i2c_tagged_rsp_t  rsp,
    input  logic                      rsp_credit,
    output logic                      scl_0,
    output logic                      sda_oe_0,
    input  logic                      sda_in_0,
    output logic                      scl_1,
    output logic                      sda_oe_1,
    input  logic                      sda_in_1
);

    import i2c_pkg::*;

    i2c_cmd_t              cmd_head_0, cmd_head_1;
    logic                  cmd_ready_0, cmd_ready_1;
    logic                  cmd_pop_0, cmd_pop_1;
    i2c_rsp_t              m_rsp_0, m_rsp_1;
    logic                  m_valid_0, m_valid_1;
    logic                  rsp_room_0, rsp_room_1;
    i2c_rsp_t              q_rsp_0, q_rsp_1;
    logic [CHAN_COUNT-1:0] rsp_avail;
    logic [CHAN_COUNT-1:0] rsp_pop;

    // channel 0
    credit_fifo #(.payload_t(i2c_cmd_t), .DEPTH(CMD_DEPTH)) cmd_fifo_0 (
        .clk, .rst_n, .push(cmd_valid_0), .push_data(cmd_0), .pop(cmd_pop_0),
        .pop_data(cmd_head_0), .not_empty(cmd_ready_0), .not_full(), .credit(cmd_credit_0)
    );

    i2c_master #(.DIVIDER(DIVIDER)) master_0 (
        .clk, .rst_n, .cmd_ready(cmd_ready_0), .cmd(cmd_head_0), .cmd_pop(cmd_pop_0),
        .rsp_valid(m_valid_0), .rsp_accept(rsp_room_0), .rsp(m_rsp_0),
        .scl_low(scl_0), .sda_oe(sda_oe_0), .sda_in(sda_in_0)
    );

    credit_fifo #(.payload_t(i2c_rsp_t), .DEPTH(RSP_DEPTH)) rsp_fifo_0 (
        .clk, .rst_n, .push(m_valid_0), .push_data(m_rsp_0), .pop(rsp_pop[0]),
        .pop_data(q_rsp_0), .not_empty(rsp_avail[0]), .not_full(rsp_room_0), .credit()
    );

    // channel 1
    credit_fifo #(.payload_t(i2c_cmd_t), .DEPTH(CMD_DEPTH)) cmd_fifo_1 (
        .clk, .rst_n, .push(cmd_valid_1), .push_data(cmd_1), .pop(cmd_pop_1),
        .pop_data(cmd_head_1), .not_empty(cmd_ready_1), .not_full(), .credit(cmd_credit_1)
    );

    i2c_master #(.DIVIDER(DIVIDER)) master_1 (
        .clk, .rst_n, .cmd_ready(cmd_ready_1), .cmd(cmd_head_1), .cmd_pop(cmd_pop_1),
        .rsp_valid(m_valid_1), .rsp_accept(rsp_room_1), .rsp(m_rsp_1),
        .scl_low(scl_1), .sda_oe(sda_oe_1), .sda_in(sda_in_1)
    );

    credit_fifo #(.payload_t(i2c_rsp_t), .DEPTH(RSP_DEPTH)) rsp_fifo_1 (
        .clk, .rst_n, .push(m_valid_1), .push_data(m_rsp_1), .pop(rsp_pop[1]),
        .pop_data(q_rsp_1), .not_empty(rsp_avail[1]), .not_full(rsp_room_1), .credit()
    );

    result_merger #(.OUT_CREDITS(OUT_CREDITS)) merger_i (
        .clk, .rst_n,
        .rsp0(q_rsp_0), .rsp1(q_rsp_1), .avail0(rsp_avail[0]), .avail1(rsp_avail[1]),
        .pop0(rsp_pop[0]), .pop1(rsp_pop[1]),
        .rsp_valid, .rsp, .rsp_credit
    );

endmodule

//--- i2c_target_model.sv
`timescale 1ns/10ps

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  logic scl,
    input  logic sda,
    output logic drive_low
);

    typedef enum {
        T_IDLE,
        T_ADDR,
        T_AACK,
        T_WR,
        T_WACK,
        T_RD,
        T_RACK
    } tstate_t;

    tstate_t    state = T_IDLE;
    int         bit_cnt = 0;
    logic [7:0] sh = '0;
    logic       rw = 1'b0;
    logic [7:0] rd_byte = '0;
    logic [7:0] rd_count = {1'b0, ADDR} ^ 8'hA5;
    logic       master_ack = 1'b0;
    logic       scl_prev = 1'b1;
    logic       sda_prev = 1'b1;

    // bytes written by the master, read by the testbench
    logic [7:0] wr_log [1024];
    int         wr_count = 0;

    initial begin
        drive_low = 1'b0;
    end

    always begin
        @(scl or sda);
        if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda === 1'b0) begin
            // start or repeated start
            state     = T_ADDR;
            bit_cnt   = 0;
            sh        = '0;
            drive_low = 1'b0;
        end else if (scl === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0
                     && sda === 1'b1) begin
            state     = T_IDLE;
            drive_low = 1'b0;
        end else if (scl === 1'b1 && scl_prev === 1'b0) begin
            // sample on rising SCL
            case (state)
                T_ADDR, T_WR: begin
                    sh      = {sh[6:0], sda};
                    bit_cnt = bit_cnt + 1;
                end
                T_RD: begin
                    bit_cnt = bit_cnt + 1;
                end
                T_RACK: begin
                    master_ack = (sda === 1'b0);
                end
                default: begin
                end
            endcase
        end else if (scl === 1'b0 && scl_prev === 1'b1) begin
            // change SDA just after falling SCL
            #1;
            case (state)
                T_ADDR: begin
                    if (bit_cnt == 8) begin
                        if (sh[7:1] == ADDR) begin
                            drive_low = 1'b1;
                            rw        = sh[0];
                            state     = T_AACK;
                        end else begin
                            state = T_IDLE;
                        end
                    end
                end
                T_AACK: begin
                    bit_cnt = 0;
                    sh      = '0;
                    if (rw) begin
                        rd_byte   = rd_count;
                        drive_low = !rd_byte[7];
                        state     = T_RD;
                    end else begin
                        drive_low = 1'b0;
                        state     = T_WR;
                    end
                end
                T_WR: begin
                    if (bit_cnt == 8) begin
                        wr_log[wr_count] = sh;
                        wr_count  = wr_count + 1;
                        drive_low = 1'b1;
                        state     = T_WACK;
                    end
                end
                T_WACK: begin
                    drive_low = 1'b0;
                    bit_cnt   = 0;
                    sh        = '0;
                    state     = T_WR;
                end
                T_RD: begin
                    if (bit_cnt == 8) begin
                        drive_low = 1'b0;
                        rd_count  = rd_count + 8'd1;
                        state     = T_RACK;
                    end else begin
                        drive_low = !rd_byte[7 - bit_cnt];
                    end
                end
                T_RACK: begin
                    if (master_ack) begin
                        rd_byte   = rd_count;
                        drive_low = !rd_byte[7];
                        bit_cnt   = 0;
                        state     = T_RD;
                    end else begin
                        drive_low = 1'b0;
                        state     = T_IDLE;
                    end
                end
                default: begin
                end
            endcase
        end
        scl_prev = scl;
        sda_prev = sda;
    end

endmodule

//--- tb_i2c_dual.sv
`timescale 1ns/10ps

module tb_i2c_dual;

    import i2c_pkg::*;

    localparam int DIVIDER     = 4;
    localparam int CMD_DEPTH   = 4;
    localparam int RSP_DEPTH   = 2;
    localparam int OUT_CREDITS = 4;
    // 64 commands, 4 bytes, about 40 ticks a byte, plus margin
    localparam int TIMEOUT_CYCLES = 64 * 4 * 40 * DIVIDER + 20000;
    localparam logic [6:0] TADDR [2] = '{7'h50, 7'h51};

    logic            clk = 1'b0;
    logic            rst_n;
    logic            cmd_valid_0;
    logic            cmd_valid_1;
    i2c_cmd_t        cmd_0;
    i2c_cmd_t        cmd_1;
    logic            rsp_credit = 1'b0;
    logic            cmd_credit_0;
    logic            cmd_credit_1;
    logic            rsp_valid;
    i2c_tagged_rsp_t rsp;
    logic            scl_0;
    logic            scl_1;
    logic            sda_oe_0;
    logic            sda_oe_1;
    logic            sda_in_0;
    logic            sda_in_1;
    logic            scl_line_0;
    logic            scl_line_1;
    logic            tgt_drv_0;
    logic            tgt_drv_1;

    // reference model state
    i2c_rsp_t        exp_q [2][$];
    logic [7:0]      exp_wlog [2][$];
    logic [7:0]      model_rd_count [2];
    int              cmd_credits [2];
    int              cmd_pops [2];
    int              chan_results [2];
    int              last_chan_seen = -1;
    int              outstanding = 0;
    int              pending_ret = 0;
    bit              hold = 1'b0;
    int              errors = 0;
    int              results = 0;
    int              cycles = 0;

    always #20 clk = ~clk;

    // wired-AND buses
    assign scl_line_0 = !scl_0;
    assign scl_line_1 = !scl_1;
    assign sda_in_0   = !(sda_oe_0 || tgt_drv_0);
    assign sda_in_1   = !(sda_oe_1 || tgt_drv_1);

    i2c_dual_top #(
        .DIVIDER(DIVIDER),
        .CMD_DEPTH(CMD_DEPTH),
        .RSP_DEPTH(RSP_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) dut_i (
        .clk, .rst_n,
        .cmd_valid_0, .cmd_0, .cmd_credit_0,
        .cmd_valid_1, .cmd_1, .cmd_credit_1,
        .rsp_valid, .rsp, .rsp_credit,
        .scl_0, .sda_oe_0, .sda_in_0,
        .scl_1, .sda_oe_1, .sda_in_1
    );

    i2c_target_model #(.ADDR(7'h50)) tgt_0 (
        .scl(scl_line_0), .sda(sda_in_0), .drive_low(tgt_drv_0)
    );

    i2c_target_model #(.ADDR(7'h51)) tgt_1 (
        .scl(scl_line_1), .sda(sda_in_1), .drive_low(tgt_drv_1)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic take_result(input i2c_tagged_rsp_t r);
        int       c;
        int       o;
        i2c_rsp_t e;
        c = int'(r.chan);
        o = 1 - c;
        // a master holds one command, so three in flight means one sits finished
        if (c == last_chan_seen && cmd_pops[o] - chan_results[o] >= 3) begin
            $display("channel %0d passed over at %0t while it had results waiting", o, $time);
            errors = errors + 1;
        end
        last_chan_seen = c;
        outstanding  = outstanding + 1;
        pending_ret  = pending_ret + 1;
        results      = results + 1;
        chan_results[c] = chan_results[c] + 1;
        if (outstanding > OUT_CREDITS) begin
            $display("result sent without a free output credit at %0t", $time);
            errors = errors + 1;
        end
        if (exp_q[c].size() == 0) begin
            $display("result on channel %0d at %0t with no command pending", c, $time);
            errors = errors + 1;
        end else begin
            e = exp_q[c].pop_front();
            check_value("rsp.rdata", r.rsp.rdata, e.rdata);
            check_value("rsp.nack", 32'(r.rsp.nack), 32'(e.nack));
            check_value("rsp.nbytes_done", 32'(r.rsp.nbytes_done), 32'(e.nbytes_done));
        end
    endtask

    // monitor and run limit
    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles, results stopped arriving", cycles);
                $display("Something failed");
                $finish;
            end else begin
                if (cmd_credit_0) begin
                    cmd_credits[0] = cmd_credits[0] + 1;
                    cmd_pops[0]    = cmd_pops[0] + 1;
                end
                if (cmd_credit_1) begin
                    cmd_credits[1] = cmd_credits[1] + 1;
                    cmd_pops[1]    = cmd_pops[1] + 1;
                end
                if (rsp_valid) begin
                    take_result(rsp);
                end
            end
        end
    end

    // return one output credit per cycle unless withheld
    always @(posedge clk) begin
        #2;
        if (!hold && pending_ret > 0) begin
            rsp_credit  = 1'b1;
            pending_ret = pending_ret - 1;
            outstanding = outstanding - 1;
        end else begin
            rsp_credit = 1'b0;
        end
    end

    // expected result and write log from the target rules
    task automatic expect_result(input int ch, input i2c_cmd_t c);
        i2c_rsp_t e;
        int       n;
        n = int'(c.nbytes);
        e = '0;
        if (c.addr != TADDR[ch]) begin
            e.nack = 1'b1;
        end else begin
            e.nbytes_done = c.nbytes;
            for (int k = 0; k < n; k++) begin
                if (c.rw) begin
                    e.rdata = {e.rdata[23:0], model_rd_count[ch]};
                    model_rd_count[ch] = model_rd_count[ch] + 8'd1;
                end else begin
                    exp_wlog[ch].push_back(c.wdata[8 * (n - 1 - k) +: 8]);
                end
            end
        end
        exp_q[ch].push_back(e);
    endtask

    task automatic issue_cmds(input int ch, input int count);
        i2c_cmd_t c;
        for (int i = 0; i < count; i++) begin
            c = '0;
            if ($urandom % 4 != 0) begin
                c.addr = TADDR[ch];
            end else begin
                c.addr = 7'($urandom % 128);
                while (c.addr == TADDR[ch]) begin
                    c.addr = 7'($urandom % 128);
                end
            end
            c.rw     = 1'($urandom % 2);
            c.nbytes = 3'(1 + $urandom % 4);
            c.wdata  = $urandom;
            c.stop   = ($urandom % 4 != 0);
            @(posedge clk);
            #2;
            while (cmd_credits[ch] == 0) begin
                @(posedge clk);
                #2;
            end
            expect_result(ch, c);
            cmd_credits[ch] = cmd_credits[ch] - 1;
            if (ch == 0) begin
                cmd_0       = c;
                cmd_valid_0 = 1'b1;
            end else begin
                cmd_1       = c;
                cmd_valid_1 = 1'b1;
            end
            @(posedge clk);
            #2;
            if (ch == 0) begin
                cmd_valid_0 = 1'b0;
            end else begin
                cmd_valid_1 = 1'b0;
            end
            repeat ($urandom % 4) @(posedge clk);
        end
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || pending_ret != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic check_wlog(input int ch);
        int got_count;
        got_count = (ch == 0) ? tgt_0.wr_count : tgt_1.wr_count;
        check_value("target wr_count", 32'(got_count), 32'(exp_wlog[ch].size()));
        for (int i = 0; i < exp_wlog[ch].size() && i < got_count; i++) begin
            if (ch == 0) begin
                check_value("target 0 wr_log", 32'(tgt_0.wr_log[i]), 32'(exp_wlog[0][i]));
            end else begin
                check_value("target 1 wr_log", 32'(tgt_1.wr_log[i]), 32'(exp_wlog[1][i]));
            end
        end
    endtask

    task automatic run_test(input string name, input int n0, input int n1,
                            input bit withhold);
        int err_start;
        int res_start;
        int ch0_start;
        int ch1_start;
        err_start = errors;
        res_start = results;
        ch0_start = chan_results[0];
        ch1_start = chan_results[1];
        hold = withhold;
        fork
            issue_cmds(0, n0);
            issue_cmds(1, n1);
            begin
                if (withhold) begin
                    repeat (3000) @(posedge clk);
                    hold = 1'b0;
                end
            end
        join
        wait_drain();
        check_wlog(0);
        check_wlog(1);
        check_value("channel 0 results", 32'(chan_results[0] - ch0_start), 32'(n0));
        check_value("channel 1 results", 32'(chan_results[1] - ch1_start), 32'(n1));
        $display("test %s: %0d results, %0d errors", name, results - res_start,
                 errors - err_start);
    endtask

    initial begin
        void'($urandom(32'hc7ce2a04));
        rst_n       = 1'b0;
        cmd_valid_0 = 1'b0;
        cmd_valid_1 = 1'b0;
        cmd_0       = '0;
        cmd_1       = '0;
        cmd_credits[0] = CMD_DEPTH;
        cmd_credits[1] = CMD_DEPTH;
        cmd_pops[0] = 0;
        cmd_pops[1] = 0;
        chan_results[0] = 0;
        chan_results[1] = 0;
        model_rd_count[0] = {1'b0, TADDR[0]} ^ 8'hA5;
        model_rd_count[1] = {1'b0, TADDR[1]} ^ 8'hA5;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        run_test("bus 0 alone", 16, 0, 1'b0);
        run_test("bus 1 alone", 0, 16, 1'b0);
        run_test("both buses busy", 16, 16, 1'b0);
        run_test("output back-pressure", 8, 8, 1'b1);

        $display("total: %0d results, %0d errors", results, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- i2c_dual_top.f
i2c_pkg.sv
credit_fifo.sv
i2c_master.sv
result_merger.sv
i2c_dual_top.sv
i2c_target_model.sv
tb_i2c_dual.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f i2c_dual_top.f --top-module tb_i2c_dual \
    --Mdir obj_dir -o sim_tb_i2c_dual

./obj_dir/sim_tb_i2c_dual | tee sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
